/* dv/serial_slave_sva.sv */
// Protocol assertions for the serial bus slave, attached to every serial_slave instance by bind
`timescale 1ns/1ns
`default_nettype none

module serial_slave_sva
(
	input logic clk,
	input logic reset,
	input logic we,
	input logic re,
	input logic slave_ready,
	input logic slave_valid,
	input logic master_ready,
	input logic tx_data
);

	int unsigned fail_count = 0; // Assertion failures seen so far

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory strobes and handshakes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	one_access_per_cycle: assert property (@(posedge clk) disable iff (reset) !(we && re))
		else
		begin
			fail_count++;
			$error("we and re are high in the same cycle");
		end

	no_request_while_returning: assert property (@(posedge clk) disable iff (reset)
		slave_valid |-> !slave_ready)
		else
		begin
			fail_count++;
			$error("slave_ready is high while slave_valid is high");
		end

	bit0_held_under_backpressure: assert property (@(posedge clk) disable iff (reset)
		(slave_valid && !master_ready) |=> $stable(tx_data))
		else
		begin
			fail_count++;
			$error("tx_data moved while master_ready was low");
		end

	// Checked on the first edge after release
	quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !slave_valid)
		else
		begin
			fail_count++;
			$error("slave_valid is high right after reset");
		end

endmodule

bind serial_slave serial_slave_sva u_sva
(
	.clk          (clk),
	.reset        (reset),
	.we           (mem_bus.we),
	.re           (mem_bus.re),
	.slave_ready  (slave_ready),
	.slave_valid  (slave_valid),
	.master_ready (master_ready),
	.tx_data      (tx_data)
);

`default_nettype wire

/* dv/serial_slave_tb.sv */
// Directed testbench for the serial bus slave, compiled with sources.f and run as the top module
`timescale 1ns/1ns
`default_nettype none

`include "serial_bus_config.svh"

module serial_slave_tb
	import serial_bus_pkg::*;
();

	logic        clk = 1'b0;
	logic        reset;
	logic        master_valid;
	logic        rx_address;
	logic        rx_data;
	logic        read_en;
	logic        write_en;
	burst_len_t  burst_len;
	logic        slave_ready;
	logic        master_ready;
	logic        slave_valid;
	logic        tx_data;
	bus_data_t   ref_mem [`SB_MEM_DEPTH]; // Expected memory contents
	bit          written [`SB_MEM_DEPTH]; // Set once the model holds a known byte
	int unsigned lcg_state = 65236;
	int          errors    = 0;
	int          checks    = 0;

	serial_slave DUT (.*);

	initial
	begin
		forever #10 clk = ~clk;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16; // Upper bits have the longer period
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_test(input string name, input int first_err);
		$display("Test %-12s finished with %0d errors", name, errors - first_err);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus helpers, all stepping on falling edges
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic wait_for_ready();
		int t;
		t = 0;
		while (!slave_ready && t < 50)
		begin
			@(negedge clk);
			t++;
		end
		if (!slave_ready)
		begin
			errors++;
			$display("Timed out waiting for slave_ready to rise");
		end
	endtask

	task automatic send_first(input bus_addr_t addr, input bus_data_t data, input logic rd,
		input logic wr, input burst_len_t blen);
		int i;
		@(negedge clk);
		master_valid = 1'b1;
		rx_address   = addr[0];
		rx_data      = data[0];
		read_en      = rd;
		write_en     = wr;
		burst_len    = blen;
		wait_for_ready(); // Accepted on the next rising edge
		for (i = 1; i < `SB_ADDR_W; i++)
		begin
			@(negedge clk);
			master_valid = 1'b0;
			rx_address   = addr[i];
			rx_data      = (i < `SB_DATA_W) ? data[i] : 1'b0;
		end
	endtask

	task automatic send_next(input bus_data_t data);
		int i;
		@(negedge clk);
		master_valid = 1'b1;
		rx_data      = data[0];
		wait_for_ready();
		for (i = 1; i < `SB_DATA_W; i++)
		begin
			@(negedge clk);
			master_valid = 1'b0;
			rx_data      = data[i];
		end
	endtask

	task automatic get_byte(input int hold, input logic exp_bit0, output bus_data_t data);
		int t;
		int i;
		@(negedge clk); // Step past the last bit of any previous byte
		master_ready = (hold == 0);
		t = 0;
		while (!slave_valid && t < 50)
		begin
			@(negedge clk);
			t++;
		end
		if (!slave_valid)
		begin
			errors++;
			$display("Timed out waiting for slave_valid to rise");
		end
		repeat (hold)
		begin
			check("slave_valid", slave_valid, 1'b1);
			check("tx_data", tx_data, exp_bit0);
			@(negedge clk);
		end
		master_ready = 1'b1;
		for (i = 0; i < `SB_DATA_W; i++)
		begin
			data[i] = tx_data;
			if (i < `SB_DATA_W - 1)
				@(negedge clk);
		end
	endtask

	task automatic write_byte(input bus_addr_t addr, input bus_data_t data);
		send_first(addr, data, 1'b0, 1'b1, '0);
		ref_mem[addr] = data;
		written[addr] = 1'b1;
	endtask

	task automatic read_check(input bus_addr_t addr, input int hold);
		bus_data_t got;
		send_first(addr, '0, 1'b1, 1'b0, '0);
		get_byte(hold, ref_mem[addr][0], got);
		check("tx_data", got, ref_mem[addr]);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic reset_values();
		int first_err;
		first_err = errors;
		check("slave_ready", slave_ready, 1'b1);
		check("slave_valid", slave_valid, 1'b0);
		report_test("reset", first_err);
	endtask

	task automatic single_write_read();
		int        first_err;
		bus_addr_t addr;
		first_err = errors;
		addr = bus_addr_t'(lcg_next());
		write_byte(addr, bus_data_t'(lcg_next()));
		read_check(addr, 0);
		report_test("single", first_err);
	endtask

	// Four-byte write burst, read back as one burst or as single reads
	task automatic test_burst(input bus_addr_t start, input logic burst_read, input string name);
		int        first_err;
		int        i;
		bus_data_t data;
		first_err = errors;
		for (i = 0; i < 4; i++)
		begin
			data = bus_data_t'(lcg_next());
			ref_mem[bus_addr_t'(start + i)] = data; // Address wraps at the top of memory
			written[bus_addr_t'(start + i)] = 1'b1;
			if (i == 0)
				send_first(start, data, 1'b0, 1'b1, burst_len_t'(3));
			else
				send_next(data);
		end
		if (burst_read)
		begin
			send_first(start, '0, 1'b1, 1'b0, burst_len_t'(3));
			for (i = 0; i < 4; i++)
			begin
				get_byte(0, ref_mem[bus_addr_t'(start + i)][0], data);
				check("tx_data", data, ref_mem[bus_addr_t'(start + i)]);
			end
		end
		else
		begin
			for (i = 0; i < 4; i++)
				read_check(bus_addr_t'(start + i), 0);
		end
		report_test(name, first_err);
	endtask

	task automatic backpressure_read();
		int        first_err;
		bus_addr_t addr;
		first_err = errors;
		addr = bus_addr_t'(lcg_next());
		write_byte(addr, bus_data_t'(lcg_next()));
		read_check(addr, 1 + lcg_next() % 8);
		report_test("backpressure", first_err);
	endtask

	task automatic random_traffic();
		int        first_err;
		int        i;
		bus_addr_t addr;
		first_err = errors;
		for (i = 0; i < 20; i++)
		begin
			addr = bus_addr_t'(12'h100 + lcg_next() % 16); // Small window so reads find data
			if (lcg_next() % 2 == 0)
				write_byte(addr, bus_data_t'(lcg_next()));
			else if (written[addr])
				read_check(addr, 0);
		end
		report_test("random", first_err);
	endtask

	initial
	begin
		reset        = 1'b1;
		master_valid = 1'b0;
		rx_address   = 1'b0;
		rx_data      = 1'b0;
		read_en      = 1'b0;
		write_en     = 1'b0;
		burst_len    = '0;
		master_ready = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		reset_values();
		single_write_read();
		test_burst(bus_addr_t'(lcg_next()), 1'b1, "burst");
		test_burst(bus_addr_t'(`SB_MEM_DEPTH - 2), 1'b0, "wrap");
		backpressure_read();
		random_traffic();

		if (DUT.u_sva.fail_count != 0)
		begin
			errors += DUT.u_sva.fail_count;
			$display("Protocol assertions failed %0d times", DUT.u_sva.fail_count);
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/serial_bus_pkg.sv
src/slave_mem_if.sv
src/slave_in_port.sv
src/slave_memory.sv
src/slave_out_port.sv
src/serial_slave.sv
dv/serial_slave_sva.sv
dv/serial_slave_tb.sv

/* src/serial_bus_config.svh */
// Width and depth macros for the serial bus slave, included by the package and the RTL blocks
`ifndef SERIAL_BUS_CONFIG_SVH
`define SERIAL_BUS_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus word sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SB_ADDR_W    12   // Address bits, sent LSB first on rx_address
`define SB_DATA_W    8    // Data bits per beat, LSB first on rx_data and tx_data
`define SB_BURST_W   8    // Extra beats after the first one

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Local storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SB_MEM_DEPTH 4096 // One byte per address, so 2**SB_ADDR_W

`endif

/* src/serial_bus_pkg.sv */
// Shared types for the serial bus slave, imported by the interface and the RTL blocks
`default_nettype none

`include "serial_bus_config.svh"

package serial_bus_pkg;

	typedef logic [`SB_ADDR_W-1:0]  bus_addr_t;  // One byte address
	typedef logic [`SB_DATA_W-1:0]  bus_data_t;  // One data byte
	typedef logic [`SB_BURST_W-1:0] burst_len_t; // Beats that follow the first

	// Request side sequencing
	typedef enum logic [2:0]
	{
		IDLE,            // Ready for a new transaction
		ADDR_RECEIVE,    // Shifting in address bits 1 to 11
		WRITE_ISSUE,     // we is high for this cycle
		WRITE_WAIT_BEAT, // Ready for the next write beat of a burst
		DATA_RECEIVE,    // Shifting in data bits 1 to 7 of a later beat
		READ_ISSUE,      // re is high for this cycle
		READ_WAIT_TAKEN  // Out port is still sending the byte
	} in_state_t;

	// Return side sequencing
	typedef enum logic [1:0]
	{
		OUT_IDLE,       // Nothing to send
		OUT_WAIT_READY, // Byte loaded, bit 0 on tx_data until master_ready
		OUT_SHIFT       // Bits 1 to 7 going out
	} out_state_t;

endpackage

`default_nettype wire

/* src/serial_slave.sv */
// Top level of the serial bus slave, tying request port, memory and return port together
`timescale 1ns/1ns
`default_nettype none

`include "serial_bus_config.svh"

module serial_slave
(
	input  logic                  clk,
	input  logic                  reset,
	// Request side
	input  logic                  master_valid,
	input  logic                  rx_address,
	input  logic                  rx_data,
	input  logic                  read_en,
	input  logic                  write_en,
	input  logic [`SB_BURST_W-1:0] burst_len,
	output logic                  slave_ready,
	// Read-return side
	input  logic                  master_ready,
	output logic                  slave_valid,
	output logic                  tx_data
);

	slave_mem_if mem_bus ();

	slave_in_port u_in_port
	(
		.clk          (clk),
		.reset        (reset),
		.master_valid (master_valid),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.read_en      (read_en),
		.write_en     (write_en),
		.burst_len    (burst_len),
		.slave_ready  (slave_ready),
		.mem          (mem_bus.requester)
	);

	slave_memory u_memory
	(
		.clk   (clk),
		.reset (reset),
		.mem   (mem_bus.storage)
	);

	slave_out_port u_out_port
	(
		.clk          (clk),
		.reset        (reset),
		.master_ready (master_ready),
		.slave_valid  (slave_valid),
		.tx_data      (tx_data),
		.mem          (mem_bus.reader)
	);

endmodule

`default_nettype wire

/* src/slave_in_port.sv */
// Request side of the slave: deserializes address and data and issues memory accesses per beat
`timescale 1ns/1ns
`default_nettype none

`include "serial_bus_config.svh"

module slave_in_port
	import serial_bus_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic           master_valid,
	input  logic           rx_address,
	input  logic           rx_data,
	input  logic           read_en,
	input  logic           write_en,
	input  burst_len_t     burst_len,
	output logic           slave_ready,
	slave_mem_if.requester mem
);

	localparam logic [3:0] addr_last_bit = 4'(`SB_ADDR_W - 1);
	localparam logic [3:0] data_last_bit = 4'(`SB_DATA_W - 1);

	in_state_t  state;
	logic [3:0] bit_cnt;    // Index of the bit arriving this cycle
	burst_len_t beats_left; // Beats still to come after the current one
	logic       op_read;    // Transaction type latched at the first acceptance
	logic       accept;
	bus_addr_t  addr_sr;
	bus_data_t  data_sr;

	assign accept      = master_valid & slave_ready;
	assign slave_ready = (state == IDLE) || (state == WRITE_WAIT_BEAT); // Low while busy

	assign mem.addr  = addr_sr;
	assign mem.wdata = data_sr;
	assign mem.we    = (state == WRITE_ISSUE);
	assign mem.re    = (state == READ_ISSUE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Transaction sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state      <= IDLE;
			bit_cnt    <= '0;
			beats_left <= '0;
			op_read    <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (accept && (read_en || write_en)) // A beat with neither enable is dropped
					begin
						state      <= ADDR_RECEIVE;
						bit_cnt    <= 4'd1;
						beats_left <= burst_len;
						op_read    <= read_en; // Read wins when both are high
					end
				end
				ADDR_RECEIVE:
				begin
					if (bit_cnt == addr_last_bit)
					begin
						bit_cnt <= '0;
						state   <= op_read ? READ_ISSUE : WRITE_ISSUE;
					end
					else
						bit_cnt <= bit_cnt + 4'd1;
				end
				WRITE_ISSUE:
				begin
					if (beats_left != '0)
					begin
						beats_left <= beats_left - 1'b1;
						state      <= WRITE_WAIT_BEAT;
					end
					else
						state <= IDLE;
				end
				WRITE_WAIT_BEAT:
				begin
					if (accept) // Data bit 0 of the next beat arrives now
					begin
						state   <= DATA_RECEIVE;
						bit_cnt <= 4'd1;
					end
				end
				DATA_RECEIVE:
				begin
					if (bit_cnt == data_last_bit)
					begin
						bit_cnt <= '0;
						state   <= WRITE_ISSUE;
					end
					else
						bit_cnt <= bit_cnt + 4'd1;
				end
				READ_ISSUE:
					state <= READ_WAIT_TAKEN;
				READ_WAIT_TAKEN:
				begin
					if (mem.taken) // Next read only once the previous byte has left
					begin
						if (beats_left != '0)
						begin
							beats_left <= beats_left - 1'b1;
							state      <= READ_ISSUE;
						end
						else
							state <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address and data shift registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Bits come LSB first, so each one enters at the top and moves down
	always_ff @(posedge clk)
	begin
		case (state)
			IDLE:
			begin
				if (accept)
				begin
					addr_sr <= {rx_address, addr_sr[`SB_ADDR_W-1:1]};
					data_sr <= {rx_data, data_sr[`SB_DATA_W-1:1]};
				end
			end
			ADDR_RECEIVE:
			begin
				addr_sr <= {rx_address, addr_sr[`SB_ADDR_W-1:1]};
				if (bit_cnt <= data_last_bit) // Data is shorter than the address
					data_sr <= {rx_data, data_sr[`SB_DATA_W-1:1]};
			end
			WRITE_WAIT_BEAT:
			begin
				if (accept)
					data_sr <= {rx_data, data_sr[`SB_DATA_W-1:1]};
			end
			DATA_RECEIVE:
				data_sr <= {rx_data, data_sr[`SB_DATA_W-1:1]};
			WRITE_ISSUE, READ_ISSUE:
				addr_sr <= addr_sr + 1'b1; // Burst address, wraps at the top of memory
			default:
			begin
				addr_sr <= addr_sr;
				data_sr <= data_sr;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/slave_mem_if.sv */
// Internal bus between the request port, the memory and the read-return port of the slave
`timescale 1ns/1ns
`default_nettype none

interface slave_mem_if
	import serial_bus_pkg::*;
();

	bus_addr_t addr;   // Access address
	bus_data_t wdata;  // Byte to store
	logic      we;     // One-cycle write strobe
	logic      re;     // One-cycle read strobe
	bus_data_t rdata;  // Byte read, valid with rvalid
	logic      rvalid; // Pulses one cycle after re
	logic      taken;  // Pulses on the last serialized bit

	modport requester
	(
		output addr, wdata, we, re,
		input  taken
	);

	modport storage
	(
		input  addr, wdata, we, re,
		output rdata, rvalid
	);

	modport reader
	(
		input  rdata, rvalid,
		output taken
	);

endinterface

`default_nettype wire

/* src/slave_memory.sv */
// Byte-wide local storage of the slave, written on we and read with one cycle of latency
`timescale 1ns/1ns
`default_nettype none

`include "serial_bus_config.svh"

module slave_memory
	import serial_bus_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	slave_mem_if.storage mem
);

	bus_data_t ram [`SB_MEM_DEPTH]; // Contents are undefined until written

	always_ff @(posedge clk)
	begin
		if (mem.we)
			ram[mem.addr] <= mem.wdata;
		if (mem.re)
			mem.rdata <= ram[mem.addr]; // Held until the next read
	end

	// Read strobe delayed to line up with rdata
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			mem.rvalid <= 1'b0;
		else
			mem.rvalid <= mem.re;
	end

endmodule

`default_nettype wire

/* src/slave_out_port.sv */
// Read-return side of the slave: serializes each read byte on tx_data under master_ready
`timescale 1ns/1ns
`default_nettype none

`include "serial_bus_config.svh"

module slave_out_port
	import serial_bus_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        master_ready,
	output logic        slave_valid,
	output logic        tx_data,
	slave_mem_if.reader mem
);

	localparam int cnt_w = $clog2(`SB_DATA_W);
	localparam logic [cnt_w-1:0] last_bit = cnt_w'(`SB_DATA_W - 1);

	out_state_t       state;
	logic [cnt_w-1:0] bit_cnt;  // Index of the bit on tx_data
	bus_data_t        shift_sr;

	assign slave_valid = (state != OUT_IDLE);
	assign tx_data     = shift_sr[0];
	assign mem.taken   = (state == OUT_SHIFT) && (bit_cnt == last_bit);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= OUT_IDLE;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				OUT_IDLE:
				begin
					if (mem.rvalid)
						state <= OUT_WAIT_READY;
				end
				OUT_WAIT_READY:
				begin
					if (master_ready) // Bit 0 is taken in this cycle
					begin
						state   <= OUT_SHIFT;
						bit_cnt <= cnt_w'(1);
					end
				end
				OUT_SHIFT:
				begin
					if (bit_cnt == last_bit)
					begin
						state   <= OUT_IDLE;
						bit_cnt <= '0;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				default:
					state <= OUT_IDLE;
			endcase
		end
	end

	// Once started, the byte goes out on consecutive cycles whatever master_ready does
	always_ff @(posedge clk)
	begin
		if ((state == OUT_IDLE) && mem.rvalid)
			shift_sr <= mem.rdata;
		else if (((state == OUT_WAIT_READY) && master_ready) || (state == OUT_SHIFT))
			shift_sr <= shift_sr >> 1;
	end

endmodule

`default_nettype wire
